// ==== eth_pktbuf.f ====
logic/eth_pktbuf_pkg.sv
logic/host_decode.sv
logic/packet_buffer.sv
logic/host_read_mux.sv
logic/eth_pktbuf_top.sv
testbench/eth_pktbuf_tb.sv

// ==== Bender.yml ====
package:
  name: eth_pktbuf

sources:
  # package first, then leaf blocks, then the top level
  - logic/eth_pktbuf_pkg.sv
  - logic/host_decode.sv
  - logic/packet_buffer.sv
  - logic/host_read_mux.sv
  - logic/eth_pktbuf_top.sv
  - target: test
    files:
      - testbench/eth_pktbuf_tb.sv

// ==== testbench/eth_pktbuf_tb.sv ====
// ethernet packet buffer testbench, host and line traffic checked against a byte model
`default_nettype none

module eth_pktbuf_tb
  import eth_pktbuf_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tx_ring     = 0;
  localparam int rx_ring     = 1;
  localparam int max_words   = 8;
  localparam int num_packets = 6;
  // upper bound of driven cycles over all tests
  localparam int stim_cycles = num_packets * (3 * max_words + 8) + 80;

  logic       clk_i;
  logic       rst_i;
  logic       host_v_i;
  logic       host_w_i;
  host_addr_t host_addr_i;
  data_t      host_wdata_i;
  mask_t      host_wmask_i;
  data_t      host_rdata_o;
  logic       host_rvalid_o;
  logic       line_tx_avail_o;
  pkt_size_t  line_tx_rsize_o;
  data_t      line_tx_rdata_o;
  logic       line_tx_ack_i;
  logic       line_tx_rvalid_i;
  byte_addr_t line_tx_raddr_i;
  logic       line_rx_req_o;
  logic       line_rx_send_i;
  logic       line_rx_wsize_valid_i;
  pkt_size_t  line_rx_wsize_i;
  logic       line_rx_wvalid_i;
  byte_addr_t line_rx_waddr_i;
  data_t      line_rx_wdata_i;
  mask_t      line_rx_wmask_i;

  // expected values, driven along with the access they belong to
  data_t      host_exp;
  data_t      host_exp_q;
  data_t      line_exp;
  data_t      line_exp_q;
  pkt_size_t  line_size_exp;
  logic       lvl_chk;
  logic       exp_tx_avail;
  logic       exp_rx_req;

  // reference model, ring 0 is tx and ring 1 is rx
  logic [7:0] model_mem [2][slot_count][pkt_bytes];
  pkt_size_t  model_size [2][slot_count];
  int         wp [2];
  int         rp [2];
  int         cnt [2];
  logic       err_flag;

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          test_num;
  int          test_err_base;

  eth_pktbuf_top u_eth_pktbuf_top (
    .clk_i, .rst_i,
    .host_v_i, .host_w_i, .host_addr_i, .host_wdata_i, .host_wmask_i,
    .host_rdata_o, .host_rvalid_o,
    .line_tx_avail_o, .line_tx_rsize_o, .line_tx_rdata_o,
    .line_tx_ack_i, .line_tx_rvalid_i, .line_tx_raddr_i,
    .line_rx_req_o, .line_rx_send_i, .line_rx_wsize_valid_i, .line_rx_wsize_i,
    .line_rx_wvalid_i, .line_rx_waddr_i, .line_rx_wdata_i, .line_rx_wmask_i
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // expected read data lines up with the response cycle
  always @(posedge clk_i) begin
    host_exp_q <= host_exp;
    line_exp_q <= line_exp;
  end

  a_host_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_v_i && !host_w_i) |=> host_rvalid_o)
    else begin
      $display("** Error at %0t: no host read response one cycle after the read", $time);
      errors++;
    end
  a_host_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !(host_v_i && !host_w_i) |=> !host_rvalid_o)
    else begin
      $display("** Error at %0t: host response without a read", $time);
      errors++;
    end
  a_host_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_v_i && !host_w_i) |=> host_rdata_o == host_exp_q)
    else begin
      $display("** Error at %0t: host read data %h, expected %h", $time,
               $sampled(host_rdata_o), $sampled(host_exp_q));
      errors++;
    end
  a_line_rsize: assert property (@(posedge clk_i) disable iff (rst_i)
    line_tx_rvalid_i |-> line_tx_avail_o && line_tx_rsize_o == line_size_exp)
    else begin
      $display("** Error at %0t: line tx size %0d, expected %0d", $time,
               $sampled(line_tx_rsize_o), $sampled(line_size_exp));
      errors++;
    end
  a_line_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
    line_tx_rvalid_i |=> line_tx_rdata_o == line_exp_q)
    else begin
      $display("** Error at %0t: line tx data %h, expected %h", $time,
               $sampled(line_tx_rdata_o), $sampled(line_exp_q));
      errors++;
    end
  a_levels: assert property (@(posedge clk_i) disable iff (rst_i)
    lvl_chk |-> line_tx_avail_o == exp_tx_avail && line_rx_req_o == exp_rx_req)
    else begin
      $display("** Error at %0t: tx avail %b rx req %b, expected %b %b", $time,
               $sampled(line_tx_avail_o), $sampled(line_rx_req_o),
               $sampled(exp_tx_avail), $sampled(exp_rx_req));
      errors++;
    end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic host_addr_t make_addr(logic [1:0] region, int offset);
    return {region, byte_addr_t'(offset)};
  endfunction

  // word at the current read slot, built from model bytes
  function automatic data_t model_word(int ring, int addr);
    data_t w;
    for (int b = 0; b < bytes_per_word; b++) begin
      w[b*8 +: 8] = model_mem[ring][rp[ring]][addr + b];
    end
    return w;
  endfunction

  // writes land only while the ring has a free slot
  function automatic void model_data(int ring, int addr, data_t data, mask_t mask);
    if (cnt[ring] < slot_count) begin
      for (int b = 0; b < bytes_per_word; b++) begin
        if (mask[b]) begin
          model_mem[ring][wp[ring]][addr + b] = data[b*8 +: 8];
        end
      end
    end
  endfunction

  function automatic void model_size_write(int ring, int size);
    if (cnt[ring] < slot_count) begin
      model_size[ring][wp[ring]] = pkt_size_t'(size);
    end
  endfunction

  function automatic void model_send(int ring);
    if (cnt[ring] < slot_count) begin
      cnt[ring]++;
      wp[ring] = (wp[ring] + 1) % slot_count;
    end
  endfunction

  function automatic void model_ack(int ring);
    if (cnt[ring] > 0) begin
      cnt[ring]--;
      rp[ring] = (rp[ring] + 1) % slot_count;
    end
  endfunction

  // bit 2 error, bit 1 tx free, bit 0 rx available
  function automatic data_t exp_status();
    return data_t'({err_flag, cnt[tx_ring] < slot_count, cnt[rx_ring] > 0});
  endfunction

  // one clock, strobes fall back to idle unless the caller sets them again
  task automatic next_cycle();
    @(posedge clk_i);
    host_v_i              <= 1'b0;
    host_w_i              <= 1'b0;
    line_tx_ack_i         <= 1'b0;
    line_tx_rvalid_i      <= 1'b0;
    line_rx_send_i        <= 1'b0;
    line_rx_wsize_valid_i <= 1'b0;
    line_rx_wvalid_i      <= 1'b0;
    lvl_chk               <= 1'b0;
  endtask

  task automatic host_write(host_addr_t addr, data_t data, mask_t mask);
    next_cycle();
    host_v_i     <= 1'b1;
    host_w_i     <= 1'b1;
    host_addr_i  <= addr;
    host_wdata_i <= data;
    host_wmask_i <= mask;
  endtask

  task automatic host_read(host_addr_t addr, data_t exp);
    next_cycle();
    host_v_i    <= 1'b1;
    host_w_i    <= 1'b0;
    host_addr_i <= addr;
    host_exp    <= exp;
    checks++;
  endtask

  task automatic read_status();
    host_read(make_addr(region_csr, csr_status), exp_status());
  endtask

  task automatic check_levels();
    next_cycle();
    lvl_chk      <= 1'b1;
    exp_tx_avail <= (cnt[tx_ring] > 0);
    exp_rx_req   <= (cnt[rx_ring] < slot_count);
    checks++;
  endtask

  // full words first, then one word rewritten through a random byte mask
  task automatic tx_fill(int size);
    int    nwords;
    int    addr;
    data_t data;
    mask_t mask;
    nwords = (size + 7) / 8;
    for (int w = 0; w < nwords; w++) begin
      data = {xorshift32(), xorshift32()};
      host_write(make_addr(region_tx, w * 8), data, '1);
      model_data(tx_ring, w * 8, data, '1);
    end
    addr = int'(xorshift32() % nwords) * 8;
    data = {xorshift32(), xorshift32()};
    mask = mask_t'(xorshift32());
    host_write(make_addr(region_tx, addr), data, mask);
    model_data(tx_ring, addr, data, mask);
  endtask

  task automatic tx_send(int size);
    host_write(make_addr(region_csr, csr_tx_size), data_t'(size), '1);
    model_size_write(tx_ring, size);
    host_write(make_addr(region_csr, csr_tx_send), '0, '1);
    model_send(tx_ring);
  endtask

  task automatic line_drain_tx();
    int nwords;
    nwords = (model_size[tx_ring][rp[tx_ring]] + 7) / 8;
    for (int w = 0; w < nwords; w++) begin
      next_cycle();
      line_tx_rvalid_i <= 1'b1;
      line_tx_raddr_i  <= byte_addr_t'(w * 8);
      line_exp         <= model_word(tx_ring, w * 8);
      line_size_exp    <= model_size[tx_ring][rp[tx_ring]];
      checks++;
    end
    next_cycle();
    line_tx_ack_i <= 1'b1;
    model_ack(tx_ring);
  endtask

  task automatic rx_fill(int size);
    int    nwords;
    data_t data;
    mask_t mask;
    nwords = (size + 7) / 8;
    for (int w = 0; w < nwords + 1; w++) begin
      data = {xorshift32(), xorshift32()};
      // extra pass rewrites word 0 through a partial mask
      mask = (w < nwords) ? '1 : mask_t'(xorshift32());
      next_cycle();
      line_rx_wvalid_i <= 1'b1;
      line_rx_waddr_i  <= byte_addr_t'((w % nwords) * 8);
      line_rx_wdata_i  <= data;
      line_rx_wmask_i  <= mask;
      model_data(rx_ring, (w % nwords) * 8, data, mask);
    end
    next_cycle();
    line_rx_wsize_valid_i <= 1'b1;
    line_rx_wsize_i       <= pkt_size_t'(size);
    model_size_write(rx_ring, size);
    next_cycle();
    line_rx_send_i <= 1'b1;
    model_send(rx_ring);
  endtask

  task automatic host_drain_rx();
    int nwords;
    nwords = (model_size[rx_ring][rp[rx_ring]] + 7) / 8;
    host_read(make_addr(region_csr, csr_rx_size), data_t'(model_size[rx_ring][rp[rx_ring]]));
    for (int w = 0; w < nwords; w++) begin
      host_read(make_addr(region_rx, w * 8), model_word(rx_ring, w * 8));
    end
    host_write(make_addr(region_csr, csr_rx_ack), '0, '1);
    model_ack(rx_ring);
  endtask

  task automatic wait_tx_avail();
    int n;
    n = 0;
    next_cycle();
    @(negedge clk_i);
    while (!line_tx_avail_o && n < 20) begin
      next_cycle();
      @(negedge clk_i);
      n++;
    end
    if (!line_tx_avail_o) begin
      $display("transmit packet never became available to the line side");
      errors++;
    end
  endtask

  // host polls status until rx available shows up
  task automatic poll_rx_avail();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 20) begin
      read_status();
      next_cycle();
      @(negedge clk_i);
      seen = host_rvalid_o && host_rdata_o[0];
      n++;
    end
    if (!seen) begin
      $display("receive packet never showed up in the host status");
      errors++;
    end
  endtask

  task automatic finish_test(string name);
    int new_errs;
    next_cycle();
    next_cycle();
    @(negedge clk_i);
    new_errs = errors - test_err_base;
    $display("test %0d %s: %s, %0d errors", test_num + 1, name,
             (new_errs == 0) ? "ok" : "mismatch", new_errs);
    test_num++;
    test_err_base = errors;
  endtask

  initial begin
    int    size;
    data_t data;
    rng_state     = 32'd12;
    errors        = 0;
    checks        = 0;
    test_num      = 0;
    test_err_base = 0;
    err_flag      = 1'b0;
    for (int r = 0; r < 2; r++) begin
      wp[r]  = 0;
      rp[r]  = 0;
      cnt[r] = 0;
    end
    rst_i                 = 1'b1;
    host_v_i              = 1'b0;
    host_w_i              = 1'b0;
    host_addr_i           = '0;
    host_wdata_i          = '0;
    host_wmask_i          = '0;
    line_tx_ack_i         = 1'b0;
    line_tx_rvalid_i      = 1'b0;
    line_tx_raddr_i       = '0;
    line_rx_send_i        = 1'b0;
    line_rx_wsize_valid_i = 1'b0;
    line_rx_wsize_i       = '0;
    line_rx_wvalid_i      = 1'b0;
    line_rx_waddr_i       = '0;
    line_rx_wdata_i       = '0;
    line_rx_wmask_i       = '0;
    host_exp              = '0;
    line_exp              = '0;
    line_size_exp         = '0;
    lvl_chk               = 1'b0;
    exp_tx_avail          = 1'b0;
    exp_rx_req            = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    read_status();
    check_levels();
    finish_test("reset state");

    size = 1 + int'(xorshift32() % 64);
    tx_fill(size);
    tx_send(size);
    wait_tx_avail();
    line_drain_tx();
    finish_test("host to line transmit");

    // two packets fill the ring, the third one bounces
    for (int p = 0; p < 3; p++) begin
      size = 1 + int'(xorshift32() % 64);
      tx_fill(size);
      tx_send(size);
      read_status();
    end
    wait_tx_avail();
    line_drain_tx();
    read_status();
    line_drain_tx();
    check_levels();
    finish_test("transmit ring fill and back-pressure");

    size = 1 + int'(xorshift32() % 64);
    rx_fill(size);
    poll_rx_avail();
    host_drain_rx();
    read_status();
    check_levels();
    finish_test("line to host receive");

    // misaligned write must not touch the packet being built
    size = 1 + int'(xorshift32() % 64);
    tx_fill(size);
    data = {xorshift32(), xorshift32()};
    host_write(make_addr(region_tx, 8'h03), data, '1);
    err_flag = 1'b1;
    tx_send(size);
    read_status();
    host_write(make_addr(region_csr, csr_status), '0, '1);
    err_flag = 1'b0;
    read_status();
    wait_tx_avail();
    line_drain_tx();
    finish_test("alignment errors");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((stim_cycles + 200) * 100);
    $display("run did not finish within %0d cycles", stim_cycles + 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/eth_pktbuf_top.sv ====
// ethernet packet buffer top, host register bus on one side and mac line rings on the other
`default_nettype none

module eth_pktbuf_top
  import eth_pktbuf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // host bus
  input  logic       host_v_i,
  input  logic       host_w_i,
  input  host_addr_t host_addr_i,
  input  data_t      host_wdata_i,
  input  mask_t      host_wmask_i,
  output data_t      host_rdata_o,
  output logic       host_rvalid_o,
  // line side of tx ring
  output logic       line_tx_avail_o,
  output pkt_size_t  line_tx_rsize_o,
  output data_t      line_tx_rdata_o,
  input  logic       line_tx_ack_i,
  input  logic       line_tx_rvalid_i,
  input  byte_addr_t line_tx_raddr_i,
  // line side of rx ring
  output logic       line_rx_req_o,
  input  logic       line_rx_send_i,
  input  logic       line_rx_wsize_valid_i,
  input  pkt_size_t  line_rx_wsize_i,
  input  logic       line_rx_wvalid_i,
  input  byte_addr_t line_rx_waddr_i,
  input  data_t      line_rx_wdata_i,
  input  mask_t      line_rx_wmask_i
);

  // decoder to tx ring
  logic       tx_wvalid;
  byte_addr_t tx_waddr;
  data_t      tx_wdata;
  mask_t      tx_wmask;
  logic       tx_wsize_valid;
  pkt_size_t  tx_wsize;
  logic       tx_send;
  logic       tx_req;
  // decoder to rx ring
  logic       rx_rvalid;
  byte_addr_t rx_raddr;
  logic       rx_ack;
  logic       rx_avail;
  pkt_size_t  rx_rsize;
  data_t      rx_rdata;
  // decoder to read mux
  rsel_t      rsel;
  logic       rsel_valid;
  logic       err_set;
  logic       err_clr;

  host_decode u_decode (
    .host_v_i, .host_w_i, .host_addr_i, .host_wdata_i, .host_wmask_i,
    .tx_wvalid_o(tx_wvalid), .tx_waddr_o(tx_waddr), .tx_wdata_o(tx_wdata),
    .tx_wmask_o(tx_wmask), .tx_wsize_valid_o(tx_wsize_valid), .tx_wsize_o(tx_wsize),
    .tx_send_o(tx_send), .rx_rvalid_o(rx_rvalid), .rx_raddr_o(rx_raddr),
    .rx_ack_o(rx_ack), .rsel_o(rsel), .rsel_valid_o(rsel_valid),
    .err_set_o(err_set), .err_clr_o(err_clr)
  );

  // host fills, line drains
  packet_buffer u_tx_buf (
    .clk_i, .rst_i,
    .packet_avail_o(line_tx_avail_o), .packet_ack_i(line_tx_ack_i),
    .packet_rvalid_i(line_tx_rvalid_i), .packet_raddr_i(line_tx_raddr_i),
    .packet_rdata_o(line_tx_rdata_o), .packet_rsize_o(line_tx_rsize_o),
    .packet_send_i(tx_send), .packet_req_o(tx_req),
    .packet_wsize_valid_i(tx_wsize_valid), .packet_wsize_i(tx_wsize),
    .packet_wvalid_i(tx_wvalid), .packet_waddr_i(tx_waddr),
    .packet_wdata_i(tx_wdata), .packet_wmask_i(tx_wmask)
  );

  // line fills, host drains
  packet_buffer u_rx_buf (
    .clk_i, .rst_i,
    .packet_avail_o(rx_avail), .packet_ack_i(rx_ack),
    .packet_rvalid_i(rx_rvalid), .packet_raddr_i(rx_raddr),
    .packet_rdata_o(rx_rdata), .packet_rsize_o(rx_rsize),
    .packet_send_i(line_rx_send_i), .packet_req_o(line_rx_req_o),
    .packet_wsize_valid_i(line_rx_wsize_valid_i), .packet_wsize_i(line_rx_wsize_i),
    .packet_wvalid_i(line_rx_wvalid_i), .packet_waddr_i(line_rx_waddr_i),
    .packet_wdata_i(line_rx_wdata_i), .packet_wmask_i(line_rx_wmask_i)
  );

  host_read_mux u_read_mux (
    .clk_i, .rst_i,
    .rsel_i(rsel), .rsel_valid_i(rsel_valid),
    .err_set_i(err_set), .err_clr_i(err_clr),
    .rx_avail_i(rx_avail), .tx_req_i(tx_req),
    .rx_rsize_i(rx_rsize), .rx_rdata_i(rx_rdata),
    .host_rdata_o, .host_rvalid_o
  );

endmodule

`default_nettype wire

// ==== logic/host_read_mux.sv ====
// host read return path, one cycle read data and the sticky alignment error
`default_nettype none

module host_read_mux
  import eth_pktbuf_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  rsel_t     rsel_i,
  input  logic      rsel_valid_i,
  input  logic      err_set_i,
  input  logic      err_clr_i,
  input  logic      rx_avail_i,
  input  logic      tx_req_i,
  input  pkt_size_t rx_rsize_i,
  input  data_t     rx_rdata_i,
  output data_t     host_rdata_o,
  output logic      host_rvalid_o
);

  rsel_t      rsel_r;
  logic       rvalid_r;
  logic       err_r;
  // bit 2 error, bit 1 tx free, bit 0 rx available
  logic [2:0] status_r;
  pkt_size_t  rsize_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsel_r   <= rsel_none;
      rvalid_r <= 1'b0;
      err_r    <= 1'b0;
    end else begin
      rsel_r   <= rsel_valid_i ? rsel_i : rsel_none;
      rvalid_r <= rsel_valid_i;
      // set beats clear
      if (err_set_i) begin
        err_r <= 1'b1;
      end else if (err_clr_i) begin
        err_r <= 1'b0;
      end
    end
  end

  // levels as seen in the read cycle
  always_ff @(posedge clk_i) begin
    if (rsel_valid_i) begin
      status_r <= {err_r, tx_req_i, rx_avail_i};
      rsize_r  <= rx_rsize_i;
    end
  end

  always_comb begin
    case (rsel_r)
      rsel_status:  host_rdata_o = data_t'(status_r);
      rsel_rx_size: host_rdata_o = data_t'(rsize_r);
      // already registered inside the rx buffer
      rsel_rx_data: host_rdata_o = rx_rdata_i;
      default:      host_rdata_o = '0;
    endcase
  end

  assign host_rvalid_o = rvalid_r;

endmodule

`default_nettype wire

// ==== logic/packet_buffer.sv ====
// packet slot ring, one read and one write per cycle, byte masked word memory per slot
`default_nettype none

module packet_buffer
  import eth_pktbuf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // read side
  output logic       packet_avail_o,
  input  logic       packet_ack_i,
  input  logic       packet_rvalid_i,
  input  byte_addr_t packet_raddr_i,
  output data_t      packet_rdata_o,
  output pkt_size_t  packet_rsize_o,
  // write side
  input  logic       packet_send_i,
  output logic       packet_req_o,
  input  logic       packet_wsize_valid_i,
  input  pkt_size_t  packet_wsize_i,
  input  logic       packet_wvalid_i,
  input  byte_addr_t packet_waddr_i,
  input  data_t      packet_wdata_i,
  input  mask_t      packet_wmask_i
);

  slot_ptr_t wptr_r;
  slot_ptr_t rptr_r;
  logic      wwrap_r;
  logic      rwrap_r;
  logic      full;
  logic      empty;
  logic      enq;
  logic      deq;
  logic      data_reading;
  slot_ptr_t rd_slot_r;
  data_t     slot_rdata [slot_count];
  pkt_size_t slot_size [slot_count];

  // same slot index, wrap bit tells full from empty
  assign full  = (wptr_r == rptr_r) && (wwrap_r != rwrap_r);
  assign empty = (wptr_r == rptr_r) && (wwrap_r == rwrap_r);

  assign packet_avail_o = ~empty;
  assign packet_req_o   = ~full;
  assign enq            = packet_send_i & packet_req_o;
  assign deq            = packet_ack_i & packet_avail_o;
  assign data_reading   = packet_rvalid_i & packet_avail_o;

  // slot pointers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_r  <= '0;
      wwrap_r <= 1'b0;
      rptr_r  <= '0;
      rwrap_r <= 1'b0;
    end else begin
      if (enq) begin
        wptr_r  <= (wptr_r == slot_ptr_t'(slot_count - 1)) ? '0 : wptr_r + 1'b1;
        wwrap_r <= wwrap_r ^ (wptr_r == slot_ptr_t'(slot_count - 1));
      end
      if (deq) begin
        rptr_r  <= (rptr_r == slot_ptr_t'(slot_count - 1)) ? '0 : rptr_r + 1'b1;
        rwrap_r <= rwrap_r ^ (rptr_r == slot_ptr_t'(slot_count - 1));
      end
    end
  end

  // remembers which slot the last read went to
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_slot_r <= '0;
    end else if (data_reading) begin
      rd_slot_r <= rptr_r;
    end
  end

  for (genvar i = 0; i < slot_count; i++) begin : g_slot
    logic                       slot_rd;
    logic                       slot_wr;
    logic [word_addr_width-1:0] mem_addr;
    data_t                      mem [mem_words];
    data_t                      mem_q;
    logic                       rd_en_r;
    data_t                      hold_r;
    pkt_size_t                  size_r;

    assign slot_rd  = (rptr_r == slot_ptr_t'(i)) & data_reading;
    assign slot_wr  = (wptr_r == slot_ptr_t'(i)) & packet_wvalid_i & packet_req_o;
    // single port, write address wins
    assign mem_addr = slot_wr ? packet_waddr_i[byte_addr_width-1:word_lsb]
                              : packet_raddr_i[byte_addr_width-1:word_lsb];

    // output register moves on any access, writes leave old contents on it
    always_ff @(posedge clk_i) begin
      if (slot_wr) begin
        for (int b = 0; b < bytes_per_word; b++) begin
          if (packet_wmask_i[b]) begin
            mem[mem_addr][b*8 +: 8] <= packet_wdata_i[b*8 +: 8];
          end
        end
      end
      if (slot_rd || slot_wr) begin
        mem_q <= mem[mem_addr];
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rd_en_r <= 1'b0;
      end else begin
        rd_en_r <= slot_rd & ~slot_wr;
      end
    end

    // keep last read word once the memory output moves on
    always_ff @(posedge clk_i) begin
      if (rd_en_r) begin
        hold_r <= mem_q;
      end
    end

    always_ff @(posedge clk_i) begin
      if ((wptr_r == slot_ptr_t'(i)) && packet_wsize_valid_i && packet_req_o) begin
        size_r <= packet_wsize_i;
      end
    end

    assign slot_rdata[i] = rd_en_r ? mem_q : hold_r;
    assign slot_size[i]  = size_r;

    // full/empty logic must keep the two sides on different slots
    a_slot_rw_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(slot_rd && slot_wr))
      else $error("slot %0d read and written in one cycle", i);
  end

  assign packet_rsize_o = slot_size[rptr_r];
  assign packet_rdata_o = slot_rdata[rd_slot_r];

  // both sides address whole words only
  a_waddr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    packet_wvalid_i |-> packet_waddr_i[word_lsb-1:0] == '0)
    else $error("unaligned write address %0h", packet_waddr_i);
  a_raddr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    packet_rvalid_i |-> packet_raddr_i[word_lsb-1:0] == '0)
    else $error("unaligned read address %0h", packet_raddr_i);

endmodule

`default_nettype wire

// ==== logic/host_decode.sv ====
// host access decoder, maps one bus access onto buffer strobes, csr pulses and a read select
`default_nettype none

module host_decode
  import eth_pktbuf_pkg::*;
(
  input  logic       host_v_i,
  input  logic       host_w_i,
  input  host_addr_t host_addr_i,
  input  data_t      host_wdata_i,
  input  mask_t      host_wmask_i,
  // transmit buffer write side
  output logic       tx_wvalid_o,
  output byte_addr_t tx_waddr_o,
  output data_t      tx_wdata_o,
  output mask_t      tx_wmask_o,
  output logic       tx_wsize_valid_o,
  output pkt_size_t  tx_wsize_o,
  output logic       tx_send_o,
  // receive buffer read side
  output logic       rx_rvalid_o,
  output byte_addr_t rx_raddr_o,
  output logic       rx_ack_o,
  // read mux
  output rsel_t      rsel_o,
  output logic       rsel_valid_o,
  output logic       err_set_o,
  output logic       err_clr_o
);

  logic [1:0] region;
  byte_addr_t offset;
  logic       misaligned;
  logic       is_rd;
  logic       is_wr;

  assign region     = host_addr_i[byte_addr_width+1:byte_addr_width];
  assign offset     = host_addr_i[byte_addr_width-1:0];
  // buffers are word addressed, low byte bits must be zero
  assign misaligned = (offset[word_lsb-1:0] != '0);
  assign is_rd      = host_v_i & ~host_w_i;
  assign is_wr      = host_v_i & host_w_i;

  // payload goes straight through, strobes qualify it
  assign tx_waddr_o   = offset;
  assign tx_wdata_o   = host_wdata_i;
  assign tx_wmask_o   = host_wmask_i;
  assign tx_wsize_o   = host_wdata_i[$bits(pkt_size_t)-1:0];
  assign rx_raddr_o   = offset;
  // every read gets a response, even to unmapped spots
  assign rsel_valid_o = is_rd;

  always_comb begin
    tx_wvalid_o      = 1'b0;
    tx_wsize_valid_o = 1'b0;
    tx_send_o        = 1'b0;
    rx_rvalid_o      = 1'b0;
    rx_ack_o         = 1'b0;
    err_set_o        = 1'b0;
    err_clr_o        = 1'b0;
    rsel_o           = rsel_none;
    if (host_v_i) begin
      if ((region == region_tx || region == region_rx) && misaligned) begin
        // unaligned buffer access, drop it and flag
        err_set_o = 1'b1;
      end else if (region == region_tx) begin
        tx_wvalid_o = host_w_i;
      end else if (region == region_rx) begin
        rx_rvalid_o = is_rd;
        rsel_o      = is_rd ? rsel_rx_data : rsel_none;
      end else if (region == region_csr && is_wr) begin
        err_clr_o        = (offset == csr_status);
        tx_wsize_valid_o = (offset == csr_tx_size);
        tx_send_o        = (offset == csr_tx_send);
        rx_ack_o         = (offset == csr_rx_ack);
      end else if (region == region_csr) begin
        if (offset == csr_status) begin
          rsel_o = rsel_status;
        end else if (offset == csr_rx_size) begin
          rsel_o = rsel_rx_size;
        end
      end
    end
    // region 3 has nothing behind it
    assert #0 (!(host_v_i && region == 2'd3))
      else $error("host access to unused region 3");
  end

endmodule

`default_nettype wire

// ==== logic/eth_pktbuf_pkg.sv ====
// ethernet packet buffer package with widths, word types, host address map and ring size
`default_nettype none

package eth_pktbuf_pkg;

  // datapath geometry
  localparam int data_width      = 64;
  localparam int bytes_per_word  = data_width / 8;
  localparam int word_lsb        = $clog2(bytes_per_word);
  localparam int slot_count      = 2;
  localparam int pkt_bytes       = 256;
  // 32 words per slot
  localparam int mem_words       = pkt_bytes / bytes_per_word;
  localparam int byte_addr_width = $clog2(pkt_bytes);
  localparam int word_addr_width = $clog2(mem_words);

  typedef logic [data_width-1:0]      data_t;
  typedef logic [bytes_per_word-1:0]  mask_t;
  typedef logic [byte_addr_width-1:0] byte_addr_t;
  // one extra bit so a full 256 byte packet fits
  typedef logic [byte_addr_width:0]   pkt_size_t;
  typedef logic [$clog2(slot_count)-1:0] slot_ptr_t;
  // region in [9:8], offset in [7:0]
  typedef logic [byte_addr_width+1:0] host_addr_t;

  // host regions, region 3 unused
  localparam logic [1:0] region_csr = 2'd0;
  localparam logic [1:0] region_tx  = 2'd1;
  localparam logic [1:0] region_rx  = 2'd2;

  // csr offsets inside region_csr
  localparam byte_addr_t csr_status  = 8'h00;
  localparam byte_addr_t csr_tx_size = 8'h08;
  localparam byte_addr_t csr_tx_send = 8'h10;
  localparam byte_addr_t csr_rx_size = 8'h18;
  localparam byte_addr_t csr_rx_ack  = 8'h20;

  // what the read mux returns one cycle after a host read
  typedef logic [1:0] rsel_t;
  localparam rsel_t rsel_status  = 2'd0;
  localparam rsel_t rsel_rx_size = 2'd1;
  localparam rsel_t rsel_rx_data = 2'd2;
  localparam rsel_t rsel_none    = 2'd3;

endpackage

`default_nettype wire
